/* cam_cfg.svh */
`ifndef CAM_CFG_SVH
`define CAM_CFG_SVH

// ============================================================
// frame geometry
// ============================================================

// active pixels per camera line
`define FRAME_W 32
// lines per frame
`define FRAME_H 4

// ============================================================
// frame memory packing
// ============================================================

// pixels stacked into one memory word
`define PIX_PER_CHUNK 8
// memory word width, PIX_PER_CHUNK x 16 bit pixels
`define CHUNK_W 128
// words per frame: FRAME_W * FRAME_H / PIX_PER_CHUNK
`define FRAME_CHUNKS 16

// widened colour channel and threshold width
`define CHAN_W 8

`endif

/* video_pkg.sv */
`include "cam_cfg.svh"

package video_pkg;

  // one rgb565 pixel, red in the top five bits
  typedef logic [15:0] pixel_t;

  // position counters for the incoming camera raster
  typedef logic [$clog2(`FRAME_W)-1:0] hcount_t;
  typedef logic [$clog2(`FRAME_H)-1:0] vcount_t;

  // channel select code for the mask
  // the fourth code is reserved and always masks to 0
  typedef enum logic [1:0] {
    ch_green   = 2'd0,
    ch_red     = 2'd1,
    ch_blue    = 2'd2,
    ch_invalid = 2'd3
  } channel_e;

  // byte pairing in pixel_reconstruct
  typedef enum logic {
    recon_high = 1'b0,
    recon_low  = 1'b1
  } recon_state_e;

endpackage

/* mem_pkg.sv */
`include "cam_cfg.svh"

package mem_pkg;

  // one memory word, pixel 0 in the low 16 bits
  typedef logic [`CHUNK_W-1:0] chunk_t;

  // word index inside one bank
  typedef logic [$clog2(`FRAME_CHUNKS)-1:0] chunk_addr_t;

  // double buffer select
  typedef logic bank_t;

  // per-cycle decision of the frame memory arbiter
  typedef enum logic [1:0] {
    gnt_idle  = 2'd0,
    gnt_write = 2'd1,
    gnt_read  = 2'd2
  } grant_e;

  // chunk_reader control
  typedef enum logic [1:0] {
    rd_wait_frame = 2'd0,
    rd_fetch      = 2'd1,
    rd_wait_data  = 2'd2,
    rd_drain      = 2'd3
  } reader_state_e;

endpackage

/* pixel_reconstruct.sv */
`include "cam_cfg.svh"

module pixel_reconstruct (
  input  logic              clk_camera,
  input  logic              recent_reset,
  input  logic [7:0]        cam_d_i,
  input  logic              cam_pclk_i,
  input  logic              cam_hsync_i,
  input  logic              cam_vsync_i,
  output logic              pix_valid_o,
  output video_pkg::pixel_t pix_data_o,
  output logic              pix_last_o
);
  import video_pkg::*;

  // ============================================================
  // two flop synchronizers, plus one history flop for edges
  // ============================================================
  logic [7:0] d_s1, d_s2;
  logic       pclk_s1, pclk_s2, pclk_q;
  logic       hsync_s1, hsync_s2, hsync_q;
  logic       vsync_s1, vsync_s2, vsync_q;

  always_ff @(posedge clk_camera) begin
    d_s1     <= cam_d_i;
    d_s2     <= d_s1;
    pclk_s1  <= cam_pclk_i;
    pclk_s2  <= pclk_s1;
    pclk_q   <= pclk_s2;
    hsync_s1 <= cam_hsync_i;
    hsync_s2 <= hsync_s1;
    hsync_q  <= hsync_s2;
    vsync_s1 <= cam_vsync_i;
    vsync_s2 <= vsync_s1;
    vsync_q  <= vsync_s2;
  end

  logic pclk_rise, hsync_fall, vsync_rise;

  // data is synchronized at the same depth as pclk, so d_s2 pairs with the edge
  assign pclk_rise  = pclk_s2 & ~pclk_q;
  assign hsync_fall = ~hsync_s2 & hsync_q;
  assign vsync_rise = vsync_s2 & ~vsync_q;

  // ============================================================
  // byte pairing and raster position
  // ============================================================
  recon_state_e state;
  logic [7:0]   hi_byte, lo_byte;
  logic         pair_ready;
  hcount_t      hcount;
  vcount_t      vcount;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state       <= recon_high;
      pair_ready  <= 1'b0;
      pix_valid_o <= 1'b0;
      pix_last_o  <= 1'b0;
      hcount      <= '0;
      vcount      <= '0;
    end else begin
      pair_ready  <= 1'b0;
      pix_valid_o <= pair_ready;
      // bytes only count inside the active part of a line
      if (pclk_rise && hsync_s2) begin
        if (state == recon_high) begin
          state <= recon_low;
        end else begin
          state      <= recon_high;
          pair_ready <= 1'b1;
        end
      end
      // position of the pixel leaving this cycle
      if (pair_ready) begin
        pix_last_o <= (hcount == hcount_t'(`FRAME_W - 1)) &&
                      (vcount == vcount_t'(`FRAME_H - 1));
        hcount     <= hcount + 1'b1;
      end
      // end of line, realign to a high byte
      if (hsync_fall) begin
        hcount <= '0;
        vcount <= vcount + 1'b1;
        state  <= recon_high;
      end
      // new frame wins over everything else
      if (vsync_rise) begin
        hcount <= '0;
        vcount <= '0;
        state  <= recon_high;
      end
    end
  end

  // byte and pixel payload
  always_ff @(posedge clk_camera) begin
    if (pclk_rise && hsync_s2) begin
      if (state == recon_high) begin
        hi_byte <= d_s2;
      end else begin
        lo_byte <= d_s2;
      end
    end
    if (pair_ready) begin
      pix_data_o <= {hi_byte, lo_byte};
    end
  end

endmodule

/* chunk_writer.sv */
`include "cam_cfg.svh"

module chunk_writer (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  logic                 pix_valid_i,
  input  video_pkg::pixel_t    pix_data_i,
  input  logic                 pix_last_i,
  output logic                 wr_req_o,
  output mem_pkg::bank_t       wr_bank_o,
  output mem_pkg::chunk_addr_t wr_addr_o,
  output mem_pkg::chunk_t      wr_data_o,
  input  logic                 wr_gnt_i,
  output logic                 frame_done_o,
  output mem_pkg::bank_t       done_bank_o
);
  import video_pkg::*;
  import mem_pkg::*;

  localparam int pix_w = $bits(pixel_t);
  localparam int cnt_w = $clog2(`PIX_PER_CHUNK);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`PIX_PER_CHUNK - 1);

  chunk_t           chunk_q;
  logic [cnt_w-1:0] pix_cnt;
  logic             wr_last;
  logic             chunk_full;

  // eighth pixel of a chunk arriving now
  assign chunk_full = pix_valid_i && (pix_cnt == cnt_last);

  // ============================================================
  // request and bank control
  // ============================================================
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_cnt      <= '0;
      wr_req_o     <= 1'b0;
      wr_last      <= 1'b0;
      wr_bank_o    <= '0;
      wr_addr_o    <= '0;
      frame_done_o <= 1'b0;
      done_bank_o  <= '0;
    end else begin
      frame_done_o <= 1'b0;
      if (pix_valid_i) begin
        pix_cnt <= pix_cnt + 1'b1;
      end
      // a pixel takes at least 8 cycles, the grant comes well before the next chunk
      if (chunk_full) begin
        wr_req_o <= 1'b1;
        wr_last  <= pix_last_i;
      end else if (wr_req_o && wr_gnt_i) begin
        wr_req_o <= 1'b0;
        if (wr_last) begin
          // frame complete, hand the bank to the reader
          frame_done_o <= 1'b1;
          done_bank_o  <= wr_bank_o;
          wr_bank_o    <= ~wr_bank_o;
          wr_addr_o    <= '0;
        end else begin
          wr_addr_o <= wr_addr_o + 1'b1;
        end
      end
    end
  end

  // new pixels enter at the top so pixel 0 ends in the low bits
  always_ff @(posedge clk_camera) begin
    if (pix_valid_i) begin
      chunk_q <= {pix_data_i, chunk_q[`CHUNK_W-1:pix_w]};
    end
    // write data held here while the shift register refills
    if (chunk_full) begin
      wr_data_o <= {pix_data_i, chunk_q[`CHUNK_W-1:pix_w]};
    end
  end

endmodule

/* frame_mem_arbiter.sv */
`include "cam_cfg.svh"

module frame_mem_arbiter (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  logic                 wr_req_i,
  input  mem_pkg::bank_t       wr_bank_i,
  input  mem_pkg::chunk_addr_t wr_addr_i,
  input  mem_pkg::chunk_t      wr_data_i,
  output logic                 wr_gnt_o,
  input  logic                 rd_req_i,
  input  mem_pkg::bank_t       rd_bank_i,
  input  mem_pkg::chunk_addr_t rd_addr_i,
  output logic                 rd_gnt_o,
  output mem_pkg::chunk_t      rd_data_o
);
  import mem_pkg::*;

  // ============================================================
  // two banks back to back, bank bit on top of the index
  // ============================================================
  chunk_t mem [2*`FRAME_CHUNKS];
  grant_e grant;
  logic   mem_we;

  // fixed priority: the camera cannot stall, so the writer goes first
  always_comb begin
    if (wr_req_i) begin
      grant = gnt_write;
    end else if (rd_req_i) begin
      grant = gnt_read;
    end else begin
      grant = gnt_idle;
    end
  end

  assign wr_gnt_o = (grant == gnt_write);
  assign rd_gnt_o = (grant == gnt_read);

  // no write lands while the pipeline is held in reset
  assign mem_we = wr_gnt_o && !recent_reset;

  always_ff @(posedge clk_camera) begin
    if (mem_we) begin
      mem[{wr_bank_i, wr_addr_i}] <= wr_data_i;
    end
  end

  // read port, data valid the cycle after the grant
  always_ff @(posedge clk_camera) begin
    if (rd_gnt_o) begin
      rd_data_o <= mem[{rd_bank_i, rd_addr_i}];
    end
  end

endmodule

/* chunk_reader.sv */
`include "cam_cfg.svh"

module chunk_reader (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  logic                 frame_done_i,
  input  mem_pkg::bank_t       done_bank_i,
  output logic                 rd_req_o,
  output mem_pkg::bank_t       rd_bank_o,
  output mem_pkg::chunk_addr_t rd_addr_o,
  input  logic                 rd_gnt_i,
  input  mem_pkg::chunk_t      rd_data_i,
  output logic                 pix_tvalid_o,
  output video_pkg::pixel_t    pix_tdata_o,
  output logic                 pix_tlast_o,
  input  logic                 pix_tready_i
);
  import video_pkg::*;
  import mem_pkg::*;

  localparam int pix_w = $bits(pixel_t);
  localparam int idx_w = $clog2(`PIX_PER_CHUNK);
  localparam logic [idx_w-1:0] idx_last = idx_w'(`PIX_PER_CHUNK - 1);
  localparam chunk_addr_t addr_last = chunk_addr_t'(`FRAME_CHUNKS - 1);

  reader_state_e    state;
  logic             pending;
  bank_t            pend_bank;
  logic [idx_w-1:0] pix_idx;
  chunk_t           chunk_q;
  logic             xfer;

  assign xfer = pix_tvalid_o && pix_tready_i;

  // ============================================================
  // frame tracking and fetch control
  // ============================================================
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state     <= rd_wait_frame;
      pending   <= 1'b0;
      pend_bank <= '0;
      rd_req_o  <= 1'b0;
      rd_bank_o <= '0;
      rd_addr_o <= '0;
      pix_idx   <= '0;
    end else begin
      case (state)
        rd_wait_frame: begin
          if (pending) begin
            rd_bank_o <= pend_bank;
            rd_addr_o <= '0;
            rd_req_o  <= 1'b1;
            pending   <= 1'b0;
            state     <= rd_fetch;
          end
        end
        rd_fetch: begin
          // request held until the arbiter takes it
          if (rd_gnt_i) begin
            rd_req_o <= 1'b0;
            state    <= rd_wait_data;
          end
        end
        rd_wait_data: begin
          pix_idx <= '0;
          state   <= rd_drain;
        end
        rd_drain: begin
          if (xfer) begin
            if (pix_idx != idx_last) begin
              pix_idx <= pix_idx + 1'b1;
            end else if (rd_addr_o == addr_last) begin
              state <= rd_wait_frame;
            end else begin
              // next word only once this one is empty
              rd_addr_o <= rd_addr_o + 1'b1;
              rd_req_o  <= 1'b1;
              state     <= rd_fetch;
            end
          end
        end
        default: state <= rd_wait_frame;
      endcase
      // a frame finished mid-read is kept for the next pass
      if (frame_done_i) begin
        pending   <= 1'b1;
        pend_bank <= done_bank_i;
      end
    end
  end

  // word capture and unstacking, lowest pixel first
  always_ff @(posedge clk_camera) begin
    if (state == rd_wait_data) begin
      chunk_q <= rd_data_i;
    end else if (xfer) begin
      chunk_q <= {{pix_w{1'b0}}, chunk_q[`CHUNK_W-1:pix_w]};
    end
  end

  // stream side, all taken from registers so it holds under back-pressure
  assign pix_tvalid_o = (state == rd_drain);
  assign pix_tdata_o  = chunk_q[pix_w-1:0];
  assign pix_tlast_o  = (rd_addr_o == addr_last) && (pix_idx == idx_last);

endmodule

/* mask_stage.sv */
`include "cam_cfg.svh"

module mask_stage (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic                pix_tvalid_i,
  input  video_pkg::pixel_t   pix_tdata_i,
  input  logic                pix_tlast_i,
  output logic                pix_tready_o,
  input  video_pkg::channel_e channel_sel_i,
  input  logic [`CHAN_W-1:0]  lower_i,
  input  logic [`CHAN_W-1:0]  upper_i,
  output logic                out_valid_o,
  output video_pkg::pixel_t   out_pixel_o,
  output logic                out_mask_o,
  output logic                out_last_o,
  input  logic                out_ready_i
);
  import video_pkg::*;

  logic [`CHAN_W-1:0] chan;
  logic               chan_ok;
  logic               mask;
  logic               load;

  // ============================================================
  // channel select, 565 fields padded with low zeros
  // ============================================================
  always_comb begin
    chan_ok = 1'b1;
    case (channel_sel_i)
      ch_green: chan = {pix_tdata_i[10:5], {(`CHAN_W-6){1'b0}}};
      ch_red:   chan = {pix_tdata_i[15:11], {(`CHAN_W-5){1'b0}}};
      ch_blue:  chan = {pix_tdata_i[4:0], {(`CHAN_W-5){1'b0}}};
      default: begin
        chan    = '0;
        chan_ok = 1'b0;
      end
    endcase
  end

  // inclusive window
  assign mask = chan_ok && (lower_i <= chan) && (chan <= upper_i);

  // one entry skid, refill when empty or draining this cycle
  assign pix_tready_o = !out_valid_o || out_ready_i;
  assign load         = pix_tvalid_i && pix_tready_o;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      out_valid_o <= 1'b0;
    end else if (pix_tready_o) begin
      out_valid_o <= pix_tvalid_i;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (load) begin
      out_pixel_o <= pix_tdata_i;
      out_mask_o  <= mask;
      out_last_o  <= pix_tlast_i;
    end
  end

endmodule

/* camera_frame_top.sv */
`include "cam_cfg.svh"

module camera_frame_top (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic [7:0]          cam_d_i,
  input  logic                cam_pclk_i,
  input  logic                cam_hsync_i,
  input  logic                cam_vsync_i,
  input  video_pkg::channel_e channel_sel_i,
  input  logic [`CHAN_W-1:0]  lower_i,
  input  logic [`CHAN_W-1:0]  upper_i,
  output logic                out_valid_o,
  output video_pkg::pixel_t   out_pixel_o,
  output logic                out_mask_o,
  output logic                out_last_o,
  input  logic                out_ready_i
);
  import video_pkg::*;
  import mem_pkg::*;

  // ============================================================
  // camera side
  // ============================================================
  logic        pix_valid;
  pixel_t      pix_data;
  logic        pix_last;

  // writer to memory
  logic        wr_req, wr_gnt;
  bank_t       wr_bank;
  chunk_addr_t wr_addr;
  chunk_t      wr_data;
  logic        frame_done;
  bank_t       done_bank;

  // memory to reader
  logic        rd_req, rd_gnt;
  bank_t       rd_bank;
  chunk_addr_t rd_addr;
  chunk_t      rd_data;

  // ============================================================
  // readback stream
  // ============================================================
  logic        pix_tvalid, pix_tready, pix_tlast;
  pixel_t      pix_tdata;

  pixel_reconstruct u_pixel_reconstruct (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .cam_d_i     (cam_d_i),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .pix_valid_o (pix_valid),
    .pix_data_o  (pix_data),
    .pix_last_o  (pix_last)
  );

  chunk_writer u_chunk_writer (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .pix_valid_i (pix_valid),
    .pix_data_i  (pix_data),
    .pix_last_i  (pix_last),
    .wr_req_o    (wr_req),
    .wr_bank_o   (wr_bank),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_gnt_i    (wr_gnt),
    .frame_done_o(frame_done),
    .done_bank_o (done_bank)
  );

  frame_mem_arbiter u_frame_mem_arbiter (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .wr_req_i    (wr_req),
    .wr_bank_i   (wr_bank),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_gnt_o    (wr_gnt),
    .rd_req_i    (rd_req),
    .rd_bank_i   (rd_bank),
    .rd_addr_i   (rd_addr),
    .rd_gnt_o    (rd_gnt),
    .rd_data_o   (rd_data)
  );

  chunk_reader u_chunk_reader (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .frame_done_i(frame_done),
    .done_bank_i (done_bank),
    .rd_req_o    (rd_req),
    .rd_bank_o   (rd_bank),
    .rd_addr_o   (rd_addr),
    .rd_gnt_i    (rd_gnt),
    .rd_data_i   (rd_data),
    .pix_tvalid_o(pix_tvalid),
    .pix_tdata_o (pix_tdata),
    .pix_tlast_o (pix_tlast),
    .pix_tready_i(pix_tready)
  );

  mask_stage u_mask_stage (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pix_tvalid_i (pix_tvalid),
    .pix_tdata_i  (pix_tdata),
    .pix_tlast_i  (pix_tlast),
    .pix_tready_o (pix_tready),
    .channel_sel_i(channel_sel_i),
    .lower_i      (lower_i),
    .upper_i      (upper_i),
    .out_valid_o  (out_valid_o),
    .out_pixel_o  (out_pixel_o),
    .out_mask_o   (out_mask_o),
    .out_last_o   (out_last_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int clk_period   = 20,
  parameter int reset_cycles = 8
) (
  output logic clk_camera_o,
  output logic recent_reset_o
);

  // free running camera clock
  initial begin
    clk_camera_o = 1'b0;
    forever #(clk_period / 2) clk_camera_o = ~clk_camera_o;
  end

  // reset held high for a fixed number of rising edges
  initial begin
    recent_reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_camera_o);
    recent_reset_o <= 1'b0;
  end

endmodule

/* tb_camera_frame_top.sv */
`include "cam_cfg.svh"

module tb_camera_frame_top;
  import video_pkg::*;

  localparam int num_frames     = 8;
  // frames from this index on see random back-pressure
  localparam int stall_from     = 2;
  localparam int pix_per_frame  = `FRAME_W * `FRAME_H;
  localparam int timeout_cycles = num_frames * `FRAME_W * `FRAME_H * 16 * 2;

  logic               clk_camera;
  logic               recent_reset;
  logic [7:0]         cam_d_i;
  logic               cam_pclk_i, cam_hsync_i, cam_vsync_i;
  channel_e           channel_sel_i;
  logic [`CHAN_W-1:0] lower_i, upper_i;
  logic               out_valid_o, out_mask_o, out_last_o, out_ready_i;
  pixel_t             out_pixel_o;

  // ============================================================
  // stimulus data and reference model
  // ============================================================
  logic [16:0]        lfsr_q;
  pixel_t             frame_pix [num_frames][pix_per_frame];
  channel_e           cfg_sel [num_frames];
  logic [`CHAN_W-1:0] cfg_lo [num_frames];
  logic [`CHAN_W-1:0] cfg_hi [num_frames];
  pixel_t             exp_pix_q [$];
  logic               exp_mask_q [$];
  logic               exp_last_q [$];

  // progress counters
  int   cycle_cnt  = 0;
  int   bytes_sent = 0;
  int   accepted   = 0;
  int   out_frame  = 0;
  int   cfg_idx    = 0;
  logic stall_mode = 1'b0;

  // output as seen on the previous edge
  logic   held_valid = 1'b0;
  logic   held_ready = 1'b0;
  pixel_t held_pixel;
  logic   held_mask, held_last;

  tb_clock_gen #(
    .clk_period  (20),
    .reset_cycles(8)
  ) u_clock_gen (
    .clk_camera_o  (clk_camera),
    .recent_reset_o(recent_reset)
  );

  camera_frame_top u_camera_frame_top (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_d_i      (cam_d_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .channel_sel_i(channel_sel_i),
    .lower_i      (lower_i),
    .upper_i      (upper_i),
    .out_valid_o  (out_valid_o),
    .out_pixel_o  (out_pixel_o),
    .out_mask_o   (out_mask_o),
    .out_last_o   (out_last_o),
    .out_ready_i  (out_ready_i)
  );

  // 17 bit fibonacci lfsr with taps 17 and 14
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[16] ^ lfsr_q[13];
    lfsr_q = {lfsr_q[15:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // channel level on an 8 bit scale where 5 bit fields step by 8 and green by 4
  function automatic logic expected_mask(input pixel_t pix, input channel_e sel,
                                         input logic [`CHAN_W-1:0] lo,
                                         input logic [`CHAN_W-1:0] hi);
    int   level;
    logic known;
    known = 1'b1;
    level = 0;
    case (sel)
      ch_red:   level = int'(pix[15:11]) * 8;
      ch_green: level = int'(pix[10:5]) * 4;
      ch_blue:  level = int'(pix[4:0]) * 8;
      default:  known = 1'b0;
    endcase
    return known && (level >= int'(lo)) && (level <= int'(hi));
  endfunction

  // random pixels and per frame thresholds with the expected stream in raster order
  task automatic build_frames();
    logic [`CHAN_W-1:0] a, b;
    pixel_t             pix;
    for (int f = 0; f < num_frames; f++) begin
      cfg_sel[f] = channel_e'(random_bits(2));
      a = `CHAN_W'(random_bits(`CHAN_W));
      b = `CHAN_W'(random_bits(`CHAN_W));
      cfg_lo[f] = (a < b) ? a : b;
      cfg_hi[f] = (a < b) ? b : a;
      // frame 1 pinned to the reserved code with a window that includes 0
      if (f == 1) begin
        cfg_sel[f] = ch_invalid;
        cfg_lo[f]  = '0;
      end
      for (int p = 0; p < pix_per_frame; p++) begin
        pix = pixel_t'(random_bits(16));
        frame_pix[f][p] = pix;
        exp_pix_q.push_back(pix);
        exp_mask_q.push_back(expected_mask(pix, cfg_sel[f], cfg_lo[f], cfg_hi[f]));
        exp_last_q.push_back(p == pix_per_frame - 1);
      end
    end
  endtask

  // ============================================================
  // camera bus model at 8 clocks per byte
  // ============================================================
  task automatic send_byte(input logic [7:0] b);
    @(posedge clk_camera);
    cam_pclk_i <= 1'b0;
    cam_d_i    <= b;
    repeat (4) @(posedge clk_camera);
    cam_pclk_i <= 1'b1;
    bytes_sent <= bytes_sent + 1;
    repeat (3) @(posedge clk_camera);
  endtask

  task automatic send_line(input int f, input int row);
    int base;
    base = row * `FRAME_W;
    @(posedge clk_camera);
    cam_hsync_i <= 1'b1;
    repeat (3) @(posedge clk_camera);
    for (int col = 0; col < `FRAME_W; col++) begin
      send_byte(frame_pix[f][base + col][15:8]);
      send_byte(frame_pix[f][base + col][7:0]);
    end
    @(posedge clk_camera);
    cam_pclk_i <= 1'b0;
    repeat (4) @(posedge clk_camera);
    cam_hsync_i <= 1'b0;
    // horizontal blanking
    repeat (12) @(posedge clk_camera);
  endtask

  task automatic send_frame(input int f);
    @(posedge clk_camera);
    cam_vsync_i <= 1'b1;
    repeat (4) @(posedge clk_camera);
    cam_vsync_i <= 1'b0;
    repeat (8) @(posedge clk_camera);
    for (int row = 0; row < `FRAME_H; row++) begin
      send_line(f, row);
    end
  endtask

  // ============================================================
  // failure reporting
  // ============================================================
  task automatic end_in_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    end_in_failure();
  endtask

  task automatic describe_failure(input string why);
    $display("%s (time %0t)", why, $time);
    end_in_failure();
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    lfsr_q = 17'd88533;
    build_frames();
    cam_d_i       <= '0;
    cam_pclk_i    <= 1'b0;
    cam_hsync_i   <= 1'b0;
    cam_vsync_i   <= 1'b0;
    channel_sel_i <= cfg_sel[0];
    lower_i       <= cfg_lo[0];
    upper_i       <= cfg_hi[0];
    out_ready_i   <= 1'b1;
    @(posedge clk_camera);
    while (recent_reset) @(posedge clk_camera);
    repeat (8) @(posedge clk_camera);
    for (int f = 0; f < num_frames; f++) begin
      // next frame waits for the first pixel of the previous one
      if (f > 0) begin
        while (accepted <= (f - 1) * pix_per_frame) @(posedge clk_camera);
      end
      if (f == stall_from) begin
        stall_mode <= 1'b1;
      end
      send_frame(f);
    end
    while (out_frame < num_frames) @(posedge clk_camera);
    repeat (32) @(posedge clk_camera);
    if (exp_pix_q.size() == 0 && out_frame == num_frames && !out_valid_o) begin
      $display("Test passed");
      $finish;
    end else begin
      describe_failure("stream ended with pixels missing or extra output pending");
    end
  end

  // random back-pressure once stalls are enabled
  always @(posedge clk_camera) begin
    if (recent_reset || !stall_mode) begin
      out_ready_i <= 1'b1;
    end else begin
      out_ready_i <= lfsr_bit();
    end
  end

  always @(posedge clk_camera) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles) begin
      describe_failure("timeout, the output stream did not complete within the cycle limit");
    end
  end

  // ============================================================
  // output checks
  // ============================================================
  always @(posedge clk_camera) begin : check_outputs
    pixel_t exp_pix;
    logic   exp_mask;
    logic   exp_last;
    if (cycle_cnt != 0) begin
      // nothing may come out before the first frame has been delivered
      if (recent_reset || bytes_sent < 2 * pix_per_frame) begin
        assert (out_valid_o == 1'b0)
        else show_mismatch("out_valid_o", out_valid_o, 0);
      end
      // a stalled output holds its value
      if (held_valid && !held_ready) begin
        assert (out_valid_o == 1'b1)
        else show_mismatch("out_valid_o", out_valid_o, 1);
        assert (out_pixel_o == held_pixel)
        else show_mismatch("out_pixel_o", out_pixel_o, held_pixel);
        assert (out_mask_o == held_mask)
        else show_mismatch("out_mask_o", out_mask_o, held_mask);
        assert (out_last_o == held_last)
        else show_mismatch("out_last_o", out_last_o, held_last);
      end
      // once the last pixel is parked in the output register the next thresholds go in
      if (!recent_reset && out_valid_o && out_last_o && cfg_idx == out_frame &&
          cfg_idx < num_frames - 1) begin
        cfg_idx       <= cfg_idx + 1;
        channel_sel_i <= cfg_sel[cfg_idx + 1];
        lower_i       <= cfg_lo[cfg_idx + 1];
        upper_i       <= cfg_hi[cfg_idx + 1];
      end
      if (!recent_reset && out_valid_o && out_ready_i) begin
        assert (exp_pix_q.size() != 0)
        else describe_failure("a pixel came out after the whole expected stream");
        exp_pix  = exp_pix_q.pop_front();
        exp_mask = exp_mask_q.pop_front();
        exp_last = exp_last_q.pop_front();
        assert (out_pixel_o == exp_pix)
        else show_mismatch("out_pixel_o", out_pixel_o, exp_pix);
        assert (out_mask_o == exp_mask)
        else show_mismatch("out_mask_o", out_mask_o, exp_mask);
        assert (out_last_o == exp_last)
        else show_mismatch("out_last_o", out_last_o, exp_last);
        accepted <= accepted + 1;
        if (exp_last) begin
          out_frame <= out_frame + 1;
        end
      end
      held_valid <= out_valid_o;
      held_ready <= out_ready_i;
      held_pixel <= out_pixel_o;
      held_mask  <= out_mask_o;
      held_last  <= out_last_o;
    end
  end

endmodule

/* camera_frame.f */
+incdir+.
video_pkg.sv
mem_pkg.sv
pixel_reconstruct.sv
chunk_writer.sv
frame_mem_arbiter.sv
chunk_reader.sv
mask_stage.sv
camera_frame_top.sv
tb_clock_gen.sv
tb_camera_frame_top.sv

/* Bender.yml */
package:
  name: camera_frame

export_include_dirs:
  - .

sources:
  - files:
      - video_pkg.sv
      - mem_pkg.sv
      - pixel_reconstruct.sv
      - chunk_writer.sv
      - frame_mem_arbiter.sv
      - chunk_reader.sv
      - mask_stage.sv
      - camera_frame_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_camera_frame_top.sv
